// File: include/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath and register file
`define XLEN 32
`define REG_COUNT 32
`define REG_AW 5

// RV32I major opcodes, only the supported ones
`define OPC_OP 7'b0110011
`define OPC_OPIMM 7'b0010011
`define OPC_LOAD 7'b0000011
`define OPC_STORE 7'b0100011
`define OPC_BRANCH 7'b1100011

`define RESET_PC 32'h0000_0000 // First fetch address

`endif

// File: logic/core_pkg.sv
package core_pkg;
`include "core_consts.svh"

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`REG_AW-1:0] reg_addr_t;

	typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor} alu_op_t;

	typedef enum logic [2:0] {kind_alu, kind_load, kind_store, kind_branch, kind_illegal} instr_kind_t;

	// One decoded instruction as handed to execute
	typedef struct packed {
		instr_kind_t kind;
		alu_op_t alu_op;
		word_t op_a;
		word_t op_b; // rs2 value, or immediate for ADDI
		word_t imm;
		reg_addr_t rd;
		logic bne; // BNE rather than BEQ
		word_t pc;
	} decoded_t;

	// Owner of the shared memory port
	typedef enum logic [1:0] {instr_own, wait_resp, data_own} port_owner_t;

endpackage

// File: logic/core_top.sv
`timescale 1ns/10ps

module core_top import core_pkg::*; (
	input logic clk,
	input logic nrst,
	output logic mem_req,
	output logic mem_write,
	output word_t mem_addr,
	output word_t mem_wdata,
	input logic mem_ack,
	input logic mem_resp_val,
	input word_t mem_rdata,
	output logic retire,
	output word_t retire_pc
);

	logic redirect;
	word_t redirect_pc;
	logic dec_free;
	logic instr_valid;
	word_t instr;
	word_t instr_pc;
	logic dec_valid;
	decoded_t dec;
	logic exe_valid;
	word_t exe_data;
	reg_addr_t exe_rd;
	logic exe_we;
	word_t exe_pc;
	logic wr_en;
	reg_addr_t wr_addr;
	word_t wr_data;

	mem_port_if fetch_port ();
	mem_port_if data_port ();

	port_arbiter i_port_arbiter (.clk, .nrst, .fetch_port, .data_port, .mem_req, .mem_write,
		.mem_addr, .mem_wdata, .mem_ack, .mem_resp_val, .mem_rdata);

	fetch_unit i_fetch_unit (.clk, .nrst, .port(fetch_port), .redirect, .redirect_pc,
		.dec_free, .instr_valid, .instr, .instr_pc);

	decode_unit i_decode_unit (.clk, .nrst, .instr_valid, .instr, .instr_pc, .dec_free,
		.wr_en, .wr_addr, .wr_data, .dec_valid, .dec, .retire);

	execute_unit i_execute_unit (.clk, .nrst, .dec_valid, .dec, .port(data_port), .exe_valid,
		.exe_data, .exe_rd, .exe_we, .exe_pc, .redirect, .redirect_pc);

	result_unit i_result_unit (.clk, .nrst, .exe_valid, .exe_data, .exe_rd, .exe_we, .exe_pc,
		.wr_en, .wr_addr, .wr_data, .retire, .retire_pc);

endmodule

// File: logic/decode_unit.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module decode_unit import core_pkg::*; (
	input logic clk,
	input logic nrst,
	input logic instr_valid,
	input word_t instr,
	input word_t instr_pc,
	output logic dec_free,
	input logic wr_en,
	input reg_addr_t wr_addr,
	input word_t wr_data,
	output logic dec_valid,
	output decoded_t dec,
	input logic retire
);

	word_t regs [`REG_COUNT];
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_addr_t rs1;
	reg_addr_t rs2;
	word_t rs1_val;
	word_t rs2_val;
	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	decoded_t dec_next;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rs1_val = (rs1 == '0) ? '0 : regs[rs1]; // x0 reads zero
	assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

	always_comb
	begin
		dec_next = '0;
		dec_next.kind = kind_illegal;
		dec_next.alu_op = alu_add;
		dec_next.op_a = rs1_val;
		dec_next.op_b = rs2_val;
		dec_next.imm = imm_i;
		dec_next.rd = instr[11:7];
		dec_next.bne = funct3[0];
		dec_next.pc = instr_pc;
		case (opcode)
			`OPC_OP:
			begin
				dec_next.kind = kind_alu;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: dec_next.alu_op = alu_add;
					{7'b0100000, 3'b000}: dec_next.alu_op = alu_sub;
					{7'b0000000, 3'b111}: dec_next.alu_op = alu_and;
					{7'b0000000, 3'b110}: dec_next.alu_op = alu_or;
					{7'b0000000, 3'b100}: dec_next.alu_op = alu_xor;
					default: dec_next.kind = kind_illegal;
				endcase
			end
			`OPC_OPIMM: // ADDI only
			begin
				dec_next.op_b = imm_i;
				if (funct3 == 3'b000)
					dec_next.kind = kind_alu;
			end
			`OPC_LOAD:
				if (funct3 == 3'b010)
					dec_next.kind = kind_load;
			`OPC_STORE:
			begin
				dec_next.imm = imm_s;
				if (funct3 == 3'b010)
					dec_next.kind = kind_store;
			end
			`OPC_BRANCH:
			begin
				dec_next.imm = imm_b;
				if (funct3[2:1] == 2'b00)
					dec_next.kind = kind_branch; // BEQ or BNE
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
			regs[wr_addr] <= wr_data;
		if (instr_valid)
			dec <= dec_next;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			dec_valid <= 1'b0;
			dec_free <= 1'b1;
		end
		else
		begin
			dec_valid <= instr_valid;
			if (instr_valid)
				dec_free <= 1'b0;
			else if (retire)
				dec_free <= 1'b1; // Next instruction may read the new value
		end
	end

	a_no_x0_write: assert property (@(posedge clk) disable iff (!nrst)
		wr_en |-> wr_addr != '0);

endmodule

// File: logic/execute_unit.sv
`timescale 1ns/10ps

module execute_unit import core_pkg::*; (
	input logic clk,
	input logic nrst,
	input logic dec_valid,
	input decoded_t dec,
	mem_port_if.client port,
	output logic exe_valid,
	output word_t exe_data,
	output reg_addr_t exe_rd,
	output logic exe_we,
	output word_t exe_pc,
	output logic redirect,
	output word_t redirect_pc
);

	word_t alu_res;
	logic taken;
	logic wait_rd; // Load acked, data pending
	logic rd_done;

	always_comb
	begin
		case (dec.alu_op)
			alu_sub: alu_res = dec.op_a - dec.op_b;
			alu_and: alu_res = dec.op_a & dec.op_b;
			alu_or: alu_res = dec.op_a | dec.op_b;
			alu_xor: alu_res = dec.op_a ^ dec.op_b;
			default: alu_res = dec.op_a + dec.op_b;
		endcase
	end

	assign taken = (dec.op_a == dec.op_b) ^ dec.bne;
	assign rd_done = port.resp_val && wait_rd;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			exe_valid <= 1'b0;
			exe_we <= 1'b0;
			redirect <= 1'b0;
			port.req <= 1'b0;
			wait_rd <= 1'b0;
		end
		else
		begin
			exe_valid <= 1'b0;
			redirect <= 1'b0;
			if (dec_valid)
			begin
				case (dec.kind)
					kind_alu:
					begin
						exe_valid <= 1'b1;
						exe_we <= 1'b1;
					end
					kind_branch:
					begin
						exe_valid <= 1'b1;
						exe_we <= 1'b0;
						redirect <= taken;
					end
					kind_load, kind_store:
					begin
						port.req <= 1'b1;
						exe_we <= (dec.kind == kind_load);
					end
					default:
					begin
						exe_valid <= 1'b1; // Illegal retires as a no-op
						exe_we <= 1'b0;
					end
				endcase
			end
			if (port.ack)
			begin
				port.req <= 1'b0;
				if (port.write)
					exe_valid <= 1'b1; // Store done at ack
				else
					wait_rd <= 1'b1;
			end
			if (rd_done)
			begin
				wait_rd <= 1'b0;
				exe_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (dec_valid)
		begin
			exe_rd <= dec.rd;
			exe_pc <= dec.pc;
			exe_data <= alu_res;
			redirect_pc <= dec.pc + dec.imm;
			port.write <= (dec.kind == kind_store);
			port.addr <= dec.op_a + dec.imm;
			port.wdata <= dec.op_b;
		end
		if (rd_done)
			exe_data <= port.rdata;
	end

	// Decode must hold the next instruction back until the access retires
	a_no_overlap: assert property (@(posedge clk) disable iff (!nrst)
		dec_valid |-> !port.req && !wait_rd);

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module fetch_unit import core_pkg::*; (
	input logic clk,
	input logic nrst,
	mem_port_if.client port,
	input logic redirect,
	input word_t redirect_pc,
	input logic dec_free,
	output logic instr_valid,
	output word_t instr,
	output word_t instr_pc
);

	word_t fetch_pc; // Next address to request
	logic outst; // Read acked, waiting on resp_val
	logic drop; // Current request belongs to a dead path
	logic buf_valid;
	word_t buf_instr;
	word_t buf_pc;
	logic resp_in;
	logic capture;
	logic start;
	logic move;

	assign resp_in = port.resp_val && outst;
	assign capture = resp_in && !drop && !redirect;
	assign start = !port.req && !outst && !buf_valid && !redirect;
	assign move = buf_valid && dec_free && !instr_valid && !redirect;

	assign port.write = 1'b0;
	assign port.wdata = '0;
	assign instr = buf_instr;
	assign instr_pc = buf_pc;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			port.req <= 1'b0;
			fetch_pc <= `RESET_PC;
			outst <= 1'b0;
			drop <= 1'b0;
			buf_valid <= 1'b0;
			instr_valid <= 1'b0;
		end
		else
		begin
			instr_valid <= move;
			if (start)
			begin
				port.req <= 1'b1;
				fetch_pc <= fetch_pc + 'd4;
			end
			else if (port.ack)
				port.req <= 1'b0;
			if (redirect)
				fetch_pc <= redirect_pc;

			if (port.ack)
				outst <= 1'b1;
			else if (resp_in)
				outst <= 1'b0;

			if (capture)
				buf_valid <= 1'b1;
			else if (move || redirect)
				buf_valid <= 1'b0;

			// Anything still in flight after a redirect is thrown away
			if (redirect)
				drop <= port.req || (outst && !port.resp_val);
			else if (resp_in)
				drop <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
			port.addr <= fetch_pc;
		if (capture)
		begin
			buf_instr <= port.rdata;
			buf_pc <= port.addr;
		end
	end

endmodule

// File: logic/mem_port_if.sv
`timescale 1ns/10ps

interface mem_port_if import core_pkg::*; ();
	logic req;
	logic write;
	word_t addr;
	word_t wdata;
	logic ack; // Request taken
	logic resp_val; // Read data pulse
	word_t rdata;

	modport client (
		output req, write, addr, wdata,
		input ack, resp_val, rdata
	);

	modport arbiter (
		input req, write, addr, wdata,
		output ack, resp_val, rdata
	);
endinterface

// File: logic/port_arbiter.sv
`timescale 1ns/10ps

module port_arbiter import core_pkg::*; (
	input logic clk,
	input logic nrst,
	mem_port_if.arbiter fetch_port,
	mem_port_if.arbiter data_port,
	output logic mem_req,
	output logic mem_write,
	output word_t mem_addr,
	output word_t mem_wdata,
	input logic mem_ack,
	input logic mem_resp_val,
	input word_t mem_rdata
);

	port_owner_t owner;
	logic fetch_outst; // Fetch read acked, data not back yet
	logic fetch_busy_next;
	logic data_done;

	// Fetch read still in flight after this cycle
	assign fetch_busy_next = (owner == instr_own && fetch_port.req && mem_ack && !fetch_port.write)
		|| (fetch_outst && !mem_resp_val);
	assign data_done = (owner == data_own)
		&& ((data_port.req && data_port.write && mem_ack) || mem_resp_val);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			owner <= instr_own;
			fetch_outst <= 1'b0;
		end
		else
		begin
			fetch_outst <= fetch_busy_next;
			case (owner)
				instr_own: // Never switch under an unacked fetch request
					if (data_port.req && (!fetch_port.req || mem_ack))
						owner <= fetch_busy_next ? wait_resp : data_own;
				wait_resp:
					if (mem_resp_val)
						owner <= data_own;
				data_own:
					if (data_done)
						owner <= instr_own;
				default: owner <= instr_own;
			endcase
		end
	end

	always_comb
	begin
		mem_req = 1'b0;
		mem_write = 1'b0;
		mem_addr = fetch_port.addr;
		mem_wdata = fetch_port.wdata;
		fetch_port.ack = 1'b0;
		fetch_port.resp_val = 1'b0;
		data_port.ack = 1'b0;
		data_port.resp_val = 1'b0;
		case (owner)
			instr_own:
			begin
				mem_req = fetch_port.req;
				mem_write = fetch_port.write;
				fetch_port.ack = mem_ack && fetch_port.req;
				fetch_port.resp_val = mem_resp_val;
			end
			wait_resp: fetch_port.resp_val = mem_resp_val; // Let the old fetch drain
			data_own:
			begin
				mem_req = data_port.req;
				mem_write = data_port.write;
				mem_addr = data_port.addr;
				mem_wdata = data_port.wdata;
				data_port.ack = mem_ack && data_port.req;
				data_port.resp_val = mem_resp_val;
			end
			default: ;
		endcase
	end

	assign fetch_port.rdata = mem_rdata;
	assign data_port.rdata = mem_rdata;

	// Outside request stays put until acked, whoever owns it
	a_req_held: assert property (@(posedge clk) disable iff (!nrst)
		mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_write));
	a_data_ack: assert property (@(posedge clk) disable iff (!nrst)
		data_port.ack |-> owner == data_own && !fetch_outst);
	// One fetch read in flight at a time
	a_fetch_ack: assert property (@(posedge clk) disable iff (!nrst)
		fetch_port.ack |-> !fetch_outst);

endmodule

// File: logic/result_unit.sv
`timescale 1ns/10ps

module result_unit import core_pkg::*; (
	input logic clk,
	input logic nrst,
	input logic exe_valid,
	input word_t exe_data,
	input reg_addr_t exe_rd,
	input logic exe_we,
	input word_t exe_pc,
	output logic wr_en,
	output reg_addr_t wr_addr,
	output word_t wr_data,
	output logic retire,
	output word_t retire_pc
);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			wr_en <= 1'b0;
			retire <= 1'b0;
		end
		else
		begin
			wr_en <= exe_valid && exe_we && (exe_rd != '0); // x0 stays zero
			retire <= exe_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (exe_valid)
		begin
			wr_addr <= exe_rd;
			wr_data <= exe_data;
			retire_pc <= exe_pc;
		end
	end

endmodule

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -f sim.f --top-module core_tb -o core_tb_sim \
	&& ./obj_dir/core_tb_sim | tee /dev/stderr | grep -q "RESULT: PASS" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: sim.f
+incdir+include
logic/core_pkg.sv
logic/mem_port_if.sv
logic/port_arbiter.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/result_unit.sv
logic/core_top.sv
tests/mem_model.sv
tests/core_tb.sv

// File: tests/core_tb.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module core_tb;

	// Retired instructions of all programs plus slack for resets and latency
	localparam int PROG_INSTRS = 44;
	localparam int CYCLES_PER_INSTR = 40;
	localparam int TIMEOUT = PROG_INSTRS * CYCLES_PER_INSTR + 5 * 10;

	logic clk;
	logic nrst;
	logic mem_req;
	logic mem_write;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic mem_ack;
	logic mem_resp_val;
	logic [31:0] mem_rdata;
	logic retire;
	logic [31:0] retire_pc;
	logic wr_seen;
	logic [31:0] wr_addr;
	logic [31:0] wr_data;
	int cycles;
	int mismatches;
	int failures;
	logic [31:0] retire_q[$];
	logic [31:0] wa_q[$];
	logic [31:0] wd_q[$];

	core_top i_core_top (.clk, .nrst, .mem_req, .mem_write, .mem_addr, .mem_wdata, .mem_ack,
		.mem_resp_val, .mem_rdata, .retire, .retire_pc);

	mem_model i_mem_model (.clk, .nrst, .mem_req, .mem_write, .mem_addr, .mem_wdata, .mem_ack,
		.mem_resp_val, .mem_rdata, .wr_seen, .wr_addr, .wr_data);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (nrst && retire)
			retire_q.push_back(retire_pc);
		if (nrst && wr_seen)
		begin
			wa_q.push_back(wr_addr);
			wd_q.push_back(wr_data);
		end
		if (cycles > TIMEOUT)
		begin
			$display("Timeout: run exceeded %0d cycles", TIMEOUT);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// RV32I instruction formats
	function automatic logic [31:0] r_type(input int f7, input int f3, input int rd,
		input int rs1, input int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `OPC_OP};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] opc, input int f3, input int rd,
		input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] store_word(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `OPC_STORE};
	endfunction

	function automatic logic [31:0] branch(input int f3, input int rs1, input int rs2,
		input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], `OPC_BRANCH};
	endfunction

	task automatic start_reset(input logic [31:0] prog[$]);
		@(posedge clk);
		#1 nrst = 1'b0;
		retire_q.delete();
		wa_q.delete();
		wd_q.delete();
		for (int i = 0; i < 256; i++)
			i_mem_model.mem[i] = 32'hc0de_0000 ^ (i * 4);
		foreach (prog[i])
			i_mem_model.mem[i] = prog[i];
	endtask

	task automatic release_reset();
		repeat (3) @(posedge clk);
		#1 nrst = 1'b1;
	endtask

	task automatic wait_retire(input int end_pc);
		do
		begin
			@(posedge clk);
			#1;
		end
		while (retire_q.size() == 0 || retire_q[$] != end_pc);
	endtask

	task automatic check_writes(input logic [31:0] ea[$], input logic [31:0] ed[$]);
		assert (wa_q.size() == ea.size())
		else
		begin
			failures++;
			$display("Wrong number of memory writes: got %0d, expected %0d", wa_q.size(), ea.size());
		end
		for (int i = 0; i < ea.size() && i < wa_q.size(); i++)
			assert (wa_q[i] == ea[i] && wd_q[i] == ed[i])
			else
			begin
				mismatches++;
				$display("Mismatch at %0t: write %0d got %h=%h, expected %h=%h", $time, i,
					wa_q[i], wd_q[i], ea[i], ed[i]);
			end
	endtask

	task automatic check_retires(input logic [31:0] exp[$]);
		assert (retire_q.size() == exp.size())
		else
		begin
			failures++;
			$display("Wrong number of retired instructions: got %0d, expected %0d",
				retire_q.size(), exp.size());
		end
		for (int i = 0; i < exp.size() && i < retire_q.size(); i++)
			assert (retire_q[i] == exp[i])
			else
			begin
				mismatches++;
				$display("Mismatch at %0t: retire %0d pc %h, expected %h", $time, i,
					retire_q[i], exp[i]);
			end
	endtask

	task automatic test_reset();
		start_reset('{branch(0, 0, 0, 0)});
		release_reset();
		assert (mem_req == 1'b0 && retire == 1'b0)
		else
		begin
			mismatches++;
			$display("Mismatch at %0t: mem_req or retire high after reset", $time);
		end
		while (!mem_req)
		begin
			@(posedge clk);
			#1;
		end
		assert (mem_addr == `RESET_PC && mem_write == 1'b0)
		else
		begin
			mismatches++;
			$display("Mismatch at %0t: first request %h write %b", $time, mem_addr, mem_write);
		end
		wait_retire(0);
	endtask

	task automatic test_alu();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		a = 100;
		b = -37;
		c = a + b;
		d = a - b;
		start_reset('{i_type(`OPC_OPIMM, 0, 1, 0, 100), i_type(`OPC_OPIMM, 0, 2, 0, -37),
			r_type(0, 0, 3, 1, 2), r_type(32, 0, 4, 1, 2), r_type(0, 7, 5, 3, 4),
			r_type(0, 6, 6, 3, 4), r_type(0, 4, 7, 3, 4), i_type(`OPC_OPIMM, 0, 8, 0, 512),
			store_word(3, 8, 0), store_word(4, 8, 4), store_word(5, 8, 8),
			store_word(6, 8, 12), store_word(7, 8, 16), branch(0, 0, 0, 0)});
		release_reset();
		wait_retire(52);
		check_writes('{512, 516, 520, 524, 528}, '{c, d, c & d, c | d, c ^ d});
	endtask

	task automatic test_load_store();
		logic [31:0] a;
		logic [31:0] b;
		a = 32'h1234_5678;
		b = 32'h0fed_cba9;
		start_reset('{i_type(`OPC_OPIMM, 0, 8, 0, 'h200), i_type(`OPC_LOAD, 2, 1, 8, 0),
			i_type(`OPC_LOAD, 2, 2, 8, 4), r_type(0, 0, 3, 1, 2), store_word(3, 8, 8),
			i_type(`OPC_OPIMM, 0, 0, 0, 55), r_type(0, 0, 4, 0, 1), store_word(0, 8, 12),
			store_word(4, 8, 16), branch(0, 0, 0, 0)});
		i_mem_model.mem['h200 >> 2] = a;
		i_mem_model.mem['h204 >> 2] = b;
		release_reset();
		wait_retire(36);
		check_writes('{'h208, 'h20c, 'h210}, '{a + b, 0, a}); // x0 still zero after ADDI
	endtask

	task automatic test_branches();
		start_reset('{i_type(`OPC_OPIMM, 0, 1, 0, 5), i_type(`OPC_OPIMM, 0, 2, 0, 5),
			branch(0, 1, 2, 8), store_word(1, 0, 'h300), branch(1, 1, 2, 8),
			store_word(2, 0, 'h304), i_type(`OPC_OPIMM, 0, 3, 0, 9), branch(1, 1, 3, 8),
			store_word(3, 0, 'h308), branch(0, 1, 3, 8), store_word(3, 0, 'h30c),
			branch(0, 0, 0, 0)});
		release_reset();
		wait_retire(44);
		// 5 == 5 takes the BEQ at 8, 5 != 9 takes the BNE at 28
		check_writes('{'h304, 'h30c}, '{5, 9});
		check_retires('{0, 4, 8, 16, 20, 24, 28, 36, 40, 44});
	endtask

	task automatic test_latency();
		logic [31:0] v;
		v = 32'h7654_3210;
		start_reset('{i_type(`OPC_OPIMM, 0, 8, 0, 'h380), i_type(`OPC_LOAD, 2, 1, 8, 0),
			store_word(1, 8, 16), i_type(`OPC_OPIMM, 0, 1, 1, 1), store_word(1, 8, 20),
			i_type(`OPC_LOAD, 2, 2, 8, 16), r_type(0, 0, 2, 2, 1), store_word(2, 8, 24),
			branch(0, 0, 0, 0)});
		i_mem_model.mem['h380 >> 2] = v;
		release_reset();
		wait_retire(32);
		check_writes('{'h390, 'h394, 'h398}, '{v, v + 1, v + v + 1});
		check_retires('{0, 4, 8, 12, 16, 20, 24, 28, 32});
	endtask

	initial
	begin
		clk = 1'b0;
		nrst = 1'b0;
		cycles = 0;
		mismatches = 0;
		failures = 0;
		test_reset();
		test_alu();
		test_load_store();
		test_branches();
		test_latency();
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: tests/mem_model.sv
`timescale 1ns/10ps

module mem_model (
	input logic clk,
	input logic nrst,
	input logic mem_req,
	input logic mem_write,
	input logic [31:0] mem_addr,
	input logic [31:0] mem_wdata,
	output logic mem_ack,
	output logic mem_resp_val,
	output logic [31:0] mem_rdata,
	output logic wr_seen,
	output logic [31:0] wr_addr,
	output logic [31:0] wr_data
);

	logic [31:0] mem [0:255]; // Loaded by the testbench
	int phase; // 0 idle, 1 waiting to ack, 2 read data pending
	int delay;
	logic [31:0] rd_addr;

	initial
	begin
		mem_ack = 1'b0;
		mem_resp_val = 1'b0;
		mem_rdata = '0;
		wr_seen = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		phase = 0;
		delay = 0;
		void'($urandom(75)); // Fixed seed for the latency draws
		// Outputs change a little after the edge, after the testbench drives nrst
		forever
		begin
			@(posedge clk);
			#2;
			mem_ack = 1'b0;
			mem_resp_val = 1'b0;
			wr_seen = 1'b0;
			if (!nrst)
				phase = 0;
			else
			begin
				if (phase == 0 && mem_req)
				begin
					delay = $urandom % 4;
					phase = 1;
				end
				if (phase == 1)
				begin
					if (delay == 0)
					begin
						mem_ack = 1'b1;
						if (mem_write)
						begin
							mem[mem_addr[9:2]] = mem_wdata;
							wr_seen = 1'b1;
							wr_addr = mem_addr;
							wr_data = mem_wdata;
							phase = 0;
						end
						else
						begin
							rd_addr = mem_addr;
							delay = $urandom % 4;
							phase = 2;
						end
					end
					else
						delay = delay - 1;
				end
				else if (phase == 2)
				begin
					if (delay == 0)
					begin
						mem_resp_val = 1'b1; // At least one cycle after ack
						mem_rdata = mem[rd_addr[9:2]];
						phase = 0;
					end
					else
						delay = delay - 1;
				end
			end
		end
	end

endmodule
